// File: vlog.f
rtl/mm_bridge_pkg.sv
rtl/gray_ptr_sync.sv
rtl/dc_fifo.sv
rtl/m0_issue_ctrl.sv
rtl/mm_clock_crossing_bridge.sv
sim/m0_mem_model.sv
sim/mm_bridge_checker.sv
sim/tb_mm_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mm_bridge -f vlog.f -o tb_mm_bridge_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mm_bridge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: sim/tb_mm_bridge.sv
/*
 * testbench for the Avalon-MM clock crossing bridge
 * unrelated 4 ns m0 and 6 ns s0 clocks, addresses kept below AREA
 * reads only touch words set by the write-fill phase
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mm_bridge;

    import mm_bridge_pkg::*;

    localparam int DW        = 32;
    localparam int AW        = 16;
    localparam int BW        = 3;
    localparam int CMD_DEPTH = 8;
    localparam int RSP_DEPTH = 8;
    localparam int AREA      = 32;
    localparam int N_MIX     = 60;
    localparam int N_RD      = 30;
    localparam int N_FULL    = CMD_DEPTH + 2;
    localparam int N_CMDS    = 2 * AREA + MAX_BURST * N_MIX + N_RD + N_FULL;
    localparam int LIMIT     = 40 * N_CMDS + 500;
    // read, write, address, burstcount, writedata, burstbegin
    localparam int CW        = 2 + AW + BW + DW + 1;

    logic          s0_clk, m0_clk, s0_reset_n, m0_reset_n;
    logic          s0_ready, s0_readdatavalid, s0_write, s0_read, s0_burstbegin;
    logic [DW-1:0] s0_readdata, s0_writedata, m0_readdata, m0_writedata;
    logic [AW-1:0] s0_address, m0_address;
    logic [BW-1:0] s0_burstcount, m0_burstcount;
    logic          m0_ready, m0_readdatavalid, m0_write, m0_read, m0_burstbegin;
    logic          hold;
    logic          saw_full;

    int            seed = 32'hf968_d6cd;
    int            mismatch_cnt = 0;
    int            fail_cnt = 0;
    int            tick = 0;
    int            s0_cyc = 0;
    int            m0_cyc = 0;
    int            exp_beats = 0;
    int            got_beats = 0;
    int            held_acc = 0;
    logic [DW-1:0] ref_mem [int];
    logic [DW-1:0] exp_rd [$];
    logic [CW-1:0] exp_cmd [$];

    mm_clock_crossing_bridge #(
        .DATA_WIDTH (DW), .ADDR_WIDTH (AW), .BURSTCOUNT_WIDTH (BW),
        .CMD_FIFO_DEPTH (CMD_DEPTH), .RSP_FIFO_DEPTH (RSP_DEPTH)
    ) u_dut (.*);

    m0_mem_model #(
        .DATA_WIDTH (DW), .ADDR_WIDTH (AW), .BURSTCOUNT_WIDTH (BW),
        .LATENCY (3), .SEED (32'hf968_d6cd)
    ) u_mem (.*);

    always #2 m0_clk = ~m0_clk;
    always #3 s0_clk = ~s0_clk;

    // ------------------------------------------------------------------------
    // host side helpers
    // ------------------------------------------------------------------------
    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic expect_low(input string name, input logic got);
        assert (got === 1'b0) else begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s got %b expected 0", $time, name, got);
        end
    endtask

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic issue(input logic rd, input logic [AW-1:0] addr, input logic [BW-1:0] bc,
                         input logic first, input logic [DW-1:0] data);
        s0_read       = rd;
        s0_write      = ~rd;
        s0_address    = addr;
        s0_burstcount = bc;
        s0_burstbegin = first;
        s0_writedata  = data;
        @(posedge s0_clk);
        while (!s0_ready) begin
            if (hold) saw_full = 1'b1;
            @(posedge s0_clk);
        end
        if (hold) held_acc++;
        exp_cmd.push_back({rd, ~rd, addr, bc, data, first});
        #1;
        s0_read  = 1'b0;
        s0_write = 1'b0;
    endtask

    // one command per beat, same address and burstcount on each
    task automatic write_burst(input int addr, input int bc);
        logic [DW-1:0] data;
        for (int i = 0; i < bc; i++) begin
            data = DW'($random(seed));
            ref_mem[addr + i] = data;
            issue(1'b0, AW'(addr), BW'(bc), i == 0, data);
        end
    endtask

    task automatic read_burst(input int addr, input int bc);
        issue(1'b1, AW'(addr), BW'(bc), 1'b1, '0);
        for (int i = 0; i < bc; i++) begin
            exp_rd.push_back(ref_mem[addr + i]);
        end
        exp_beats += bc;
    endtask

    task automatic wait_idle();
        @(posedge s0_clk);
        while (exp_cmd.size() != 0 || exp_rd.size() != 0) @(posedge s0_clk);
        #1;
    endtask

    // ------------------------------------------------------------------------
    // monitors
    // ------------------------------------------------------------------------
    // each s0 command once at m0, fields unchanged, in order
    always @(posedge m0_clk) begin
        m0_cyc++;
        if (m0_cyc <= 6) begin
            expect_low("m0_read", m0_read);
            expect_low("m0_write", m0_write);
        end
        if (m0_reset_n && (m0_read || m0_write) && m0_ready) begin
            if (exp_cmd.size() == 0) begin
                fail_cnt++;
                $display("t=%0t: m0 accepted a command that the host never sent", $time);
            end else begin
                assert ({m0_read, m0_write, m0_address, m0_burstcount, m0_writedata,
                         m0_burstbegin} == exp_cmd[0]) else begin
                    mismatch_cnt++;
                    $display("MISMATCH t=%0t m0_cmd got %h expected %h", $time,
                             {m0_read, m0_write, m0_address, m0_burstcount, m0_writedata,
                              m0_burstbegin},
                             exp_cmd[0]);
                end
                void'(exp_cmd.pop_front());
            end
        end
    end

    // read beats against the reference memory
    always @(posedge s0_clk) begin
        s0_cyc++;
        if (s0_cyc <= 6) begin
            expect_low("s0_ready", s0_ready);
            expect_low("s0_readdatavalid", s0_readdatavalid);
        end
        if (s0_readdatavalid) begin
            got_beats++;
            if (exp_rd.size() == 0) begin
                fail_cnt++;
                $display("t=%0t: read beat returned with no read outstanding", $time);
            end else begin
                assert (s0_readdata == exp_rd[0]) else begin
                    mismatch_cnt++;
                    $display("MISMATCH t=%0t s0_readdata got %h expected %h", $time,
                             s0_readdata, exp_rd[0]);
                end
                void'(exp_rd.pop_front());
            end
        end
    end

    always @(posedge s0_clk) begin
        tick++;
        if (tick > LIMIT) begin
            $display("timeout: run still busy after %0d s0 cycles", LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // test phases
    // ------------------------------------------------------------------------
    initial begin
        s0_clk = 1'b0;
        m0_clk = 1'b0;
        s0_reset_n = 1'b0;
        m0_reset_n = 1'b0;
        s0_read = 1'b0;
        s0_write = 1'b0;
        s0_address = '0;
        s0_burstcount = '0;
        s0_burstbegin = 1'b0;
        s0_writedata = '0;
        hold = 1'b0;
        saw_full = 1'b0;
        fork
            begin
                repeat (5) @(posedge m0_clk);
                #1 m0_reset_n = 1'b1;
            end
            begin
                repeat (5) @(posedge s0_clk);
                #1 s0_reset_n = 1'b1;
            end
        join
        @(posedge s0_clk);
        #1;
        // write-fill, two beat bursts
        for (int a = 0; a < AREA; a += MAX_BURST) write_burst(a, MAX_BURST);
        for (int n = 0; n < N_MIX; n++) begin
            if (rand_below(2) == 0) begin
                read_burst(rand_below(AREA - 1), 1 + rand_below(MAX_BURST));
            end else begin
                write_burst(rand_below(AREA - 1), 1 + rand_below(MAX_BURST));
            end
        end
        wait_idle();
        // back to back max bursts, throttle must engage
        for (int n = 0; n < N_RD; n++) read_burst(rand_below(AREA - 1), MAX_BURST);
        wait_idle();
        // m0 stalled for 30 cycles, command FIFO fills
        hold = 1'b1;
        fork
            begin
                repeat (30) @(posedge m0_clk);
                hold = 1'b0;
            end
            for (int n = 0; n < N_FULL; n++) write_burst(rand_below(AREA), 1);
        join
        wait_idle();
        assert (saw_full) else begin
            fail_cnt++;
            $display("s0_ready never fell while m0 was stalled");
        end
        assert (held_acc <= CMD_DEPTH) else begin
            fail_cnt++;
            $display("%0d commands accepted into a %0d deep command FIFO", held_acc, CMD_DEPTH);
        end
        // read back the whole area
        for (int a = 0; a < AREA; a += MAX_BURST) read_burst(a, MAX_BURST);
        wait_idle();
        repeat (20) @(posedge s0_clk);
        assert (got_beats == exp_beats) else begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t s0 beat count got %0d expected %0d", $time,
                     got_beats, exp_beats);
        end
        $display("checks done: %0d mismatches, %0d other errors, %0d checker failures",
                 mismatch_cnt, fail_cnt, u_dut.u_issue.u_checker.assert_fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0
            && u_dut.u_issue.u_checker.assert_fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/mm_bridge_checker.sv
/*
 * concurrent checks on the m0 issue controller, bound to every instance
 * needs the controller's internal pending_cnt
 */
`timescale 1ns/1ps
`default_nettype none

module mm_bridge_checker #(
    parameter int BURSTCOUNT_WIDTH = 3,
    parameter int RSP_FIFO_DEPTH   = 8
) (
    input logic                                            m0_clk,
    input logic                                            m0_reset_n,
    input logic                                            m0_read,
    input logic                                            m0_write,
    input logic                                            m0_ready,
    input logic                                            m0_readdatavalid,
    input logic [BURSTCOUNT_WIDTH-1:0]                     cmd_burstcount,
    input logic [mm_bridge_pkg::cnt_width(RSP_FIFO_DEPTH)-1:0] space_avail,
    input logic [mm_bridge_pkg::cnt_width(RSP_FIFO_DEPTH)-1:0] pending_cnt
);

    import mm_bridge_pkg::*;

    // failed assertions so far, read by the testbench at the end
    int assert_fail_cnt = 0;

    // stalled command is never withdrawn or changed
    a_stall_hold: assert property (@(posedge m0_clk) disable iff (!m0_reset_n)
        (m0_read || m0_write) && !m0_ready |=>
            $stable(m0_read) && $stable(m0_write) && $stable(cmd_burstcount))
        else begin
            $error("m0 command changed while stalled by m0_ready");
            assert_fail_cnt++;
        end

    // zero space means the response FIFO is full
    a_rsp_room: assert property (@(posedge m0_clk) disable iff (!m0_reset_n)
        m0_readdatavalid |-> space_avail != 0)
        else begin
            $error("read beat arrived while the response FIFO was full");
            assert_fail_cnt++;
        end

    a_pending_max: assert property (@(posedge m0_clk) disable iff (!m0_reset_n)
        int'(pending_cnt) <= RSP_FIFO_DEPTH)
        else begin
            $error("pending read words exceed the response FIFO depth");
            assert_fail_cnt++;
        end

    a_burst_range: assert property (@(posedge m0_clk) disable iff (!m0_reset_n)
        m0_read |-> cmd_burstcount != 0 && int'(cmd_burstcount) <= MAX_BURST)
        else begin
            $error("read burstcount outside 1 to MAX_BURST");
            assert_fail_cnt++;
        end

endmodule

bind m0_issue_ctrl mm_bridge_checker #(
    .BURSTCOUNT_WIDTH (BURSTCOUNT_WIDTH),
    .RSP_FIFO_DEPTH   (RSP_FIFO_DEPTH)
) u_checker (
    .m0_clk           (m0_clk),
    .m0_reset_n       (m0_reset_n),
    .m0_read          (m0_read),
    .m0_write         (m0_write),
    .m0_ready         (m0_ready),
    .m0_readdatavalid (m0_readdatavalid),
    .cmd_burstcount   (cmd_burstcount),
    .space_avail      (space_avail),
    .pending_cnt      (pending_cnt)
);

`default_nettype wire

// File: sim/m0_mem_model.sv
/*
 * m0 side slave memory for the bridge testbench
 * random m0_ready, fixed read latency, beats served in order
 * unwritten words read back as an address based fill pattern
 */
`timescale 1ns/1ps
`default_nettype none

module m0_mem_model #(
    parameter int          DATA_WIDTH       = 32,
    parameter int          ADDR_WIDTH       = 16,
    parameter int          BURSTCOUNT_WIDTH = 3,
    parameter int          LATENCY          = 3,
    parameter logic [31:0] SEED             = 32'h1
) (
    input  logic                        m0_clk,
    input  logic                        m0_reset_n,
    // forces m0_ready low while set
    input  logic                        hold,
    output logic                        m0_ready,
    input  logic                        m0_read,
    input  logic                        m0_write,
    input  logic [ADDR_WIDTH-1:0]       m0_address,
    input  logic [BURSTCOUNT_WIDTH-1:0] m0_burstcount,
    input  logic [DATA_WIDTH-1:0]       m0_writedata,
    output logic [DATA_WIDTH-1:0]       m0_readdata,
    output logic                        m0_readdatavalid
);

    logic [DATA_WIDTH-1:0] mem [int];
    logic [DATA_WIDTH-1:0] rsp_data [$];
    int                    rsp_due [$];
    int                    seed = SEED;
    int                    cyc = 0;
    int                    wr_beat = 0;
    int                    wr_base = 0;

    // every address bit changes the word
    function automatic logic [DATA_WIDTH-1:0] fill_word(input int a);
        return DATA_WIDTH'((a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f);
    endfunction

    initial begin
        m0_ready         = 1'b0;
        m0_readdata      = '0;
        m0_readdatavalid = 1'b0;
    end

    always @(posedge m0_clk or negedge m0_reset_n) begin
        if (!m0_reset_n) begin
            rsp_data.delete();
            rsp_due.delete();
            wr_beat          = 0;
            m0_ready         = 1'b0;
            m0_readdatavalid = 1'b0;
        end else begin
            cyc++;
            // write beats land at base, base+1
            if (m0_write && m0_ready) begin
                if (wr_beat == 0) begin
                    wr_base = int'(m0_address);
                end
                mem[wr_base + wr_beat] = m0_writedata;
                wr_beat = (wr_beat + 1 >= int'(m0_burstcount)) ? 0 : wr_beat + 1;
            end
            // read data taken now, returned after LATENCY edges
            if (m0_read && m0_ready) begin
                for (int i = 0; i < int'(m0_burstcount); i++) begin
                    rsp_data.push_back(mem.exists(int'(m0_address) + i) ?
                                       mem[int'(m0_address) + i] :
                                       fill_word(int'(m0_address) + i));
                    rsp_due.push_back(cyc + LATENCY);
                end
            end
            #1;
            m0_ready = hold ? 1'b0 : (($random(seed) & 3) != 0);
            // one beat per cycle, seen at the next edge
            if (rsp_due.size() != 0 && rsp_due[0] <= cyc + 1) begin
                m0_readdatavalid = 1'b1;
                m0_readdata      = rsp_data.pop_front();
                void'(rsp_due.pop_front());
            end else begin
                m0_readdatavalid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/mm_clock_crossing_bridge.sv
/*
 * Avalon-MM clock crossing bridge, s0 host side to m0 slave side
 * bursts of 1 or 2 words, one command per write beat
 * FIFO depths powers of two, no byte enables, no write responses
 */
`timescale 1ns/1ps
`default_nettype none

module mm_clock_crossing_bridge #(
    parameter int DATA_WIDTH       = mm_bridge_pkg::DEF_DATA_WIDTH,
    parameter int ADDR_WIDTH       = mm_bridge_pkg::DEF_ADDR_WIDTH,
    parameter int BURSTCOUNT_WIDTH = mm_bridge_pkg::DEF_BURSTCOUNT_WIDTH,
    parameter int CMD_FIFO_DEPTH   = mm_bridge_pkg::DEF_CMD_FIFO_DEPTH,
    parameter int RSP_FIFO_DEPTH   = mm_bridge_pkg::DEF_RSP_FIFO_DEPTH,
    parameter int S0_SYNC_DEPTH    = mm_bridge_pkg::DEF_SYNC_DEPTH,
    parameter int M0_SYNC_DEPTH    = mm_bridge_pkg::DEF_SYNC_DEPTH
) (
    input  logic                        s0_clk,
    input  logic                        s0_reset_n,
    input  logic                        m0_clk,
    input  logic                        m0_reset_n,
    // s0 host port
    output logic                        s0_ready,
    output logic [DATA_WIDTH-1:0]       s0_readdata,
    output logic                        s0_readdatavalid,
    input  logic [BURSTCOUNT_WIDTH-1:0] s0_burstcount,
    input  logic [DATA_WIDTH-1:0]       s0_writedata,
    input  logic [ADDR_WIDTH-1:0]       s0_address,
    input  logic                        s0_write,
    input  logic                        s0_read,
    input  logic                        s0_burstbegin,
    // m0 slave port
    input  logic                        m0_ready,
    input  logic [DATA_WIDTH-1:0]       m0_readdata,
    input  logic                        m0_readdatavalid,
    output logic [BURSTCOUNT_WIDTH-1:0] m0_burstcount,
    output logic [DATA_WIDTH-1:0]       m0_writedata,
    output logic [ADDR_WIDTH-1:0]       m0_address,
    output logic                        m0_write,
    output logic                        m0_read,
    output logic                        m0_burstbegin
);

    import mm_bridge_pkg::*;

    // address, burstcount, read, write, writedata, burstbegin
    localparam int CMD_WIDTH = ADDR_WIDTH + BURSTCOUNT_WIDTH + 2 + DATA_WIDTH + 1;
    localparam int SPACE_W   = cnt_width(RSP_FIFO_DEPTH);

    // throttle cannot make progress below two max bursts of space
    if (RSP_FIFO_DEPTH < 2 * MAX_BURST) begin : g_bad_rsp_depth
        $error("response FIFO depth below two maximum bursts");
    end

    logic [CMD_WIDTH-1:0] s0_cmd;
    logic [CMD_WIDTH-1:0] m0_cmd;
    logic                 m0_cmd_valid;
    logic                 m0_cmd_ready;
    logic                 m0_cmd_read;
    logic                 m0_cmd_write;
    logic [SPACE_W-1:0]   rsp_space;

    // ------------------------------------------------------------------------
    // command path, s0 to m0
    // ------------------------------------------------------------------------
    assign s0_cmd = {s0_address, s0_burstcount, s0_read, s0_write,
                     s0_writedata, s0_burstbegin};

    dc_fifo #(
        .WIDTH         (CMD_WIDTH),
        .DEPTH         (CMD_FIFO_DEPTH),
        .WR_SYNC_DEPTH (S0_SYNC_DEPTH),
        .RD_SYNC_DEPTH (M0_SYNC_DEPTH)
    ) u_cmd_fifo (
        .in_clk      (s0_clk),
        .in_reset_n  (s0_reset_n),
        .out_clk     (m0_clk),
        .out_reset_n (m0_reset_n),
        .in_data     (s0_cmd),
        .in_valid    (s0_read | s0_write),
        .in_ready    (s0_ready),
        .out_data    (m0_cmd),
        .out_valid   (m0_cmd_valid),
        .out_ready   (m0_cmd_ready),
        .space_avail ()
    );

    // same field order as the packing above
    assign {m0_address, m0_burstcount, m0_cmd_read, m0_cmd_write,
            m0_writedata, m0_burstbegin} = m0_cmd;

    m0_issue_ctrl #(
        .BURSTCOUNT_WIDTH (BURSTCOUNT_WIDTH),
        .RSP_FIFO_DEPTH   (RSP_FIFO_DEPTH)
    ) u_issue (
        .m0_clk           (m0_clk),
        .m0_reset_n       (m0_reset_n),
        .cmd_valid        (m0_cmd_valid),
        .cmd_read         (m0_cmd_read),
        .cmd_write        (m0_cmd_write),
        .cmd_burstcount   (m0_burstcount),
        .cmd_ready        (m0_cmd_ready),
        .m0_ready         (m0_ready),
        .m0_readdatavalid (m0_readdatavalid),
        .space_avail      (rsp_space),
        .m0_read          (m0_read),
        .m0_write         (m0_write)
    );

    // ------------------------------------------------------------------------
    // response path, m0 to s0, never back-pressured
    // ------------------------------------------------------------------------
    // overflow is prevented by the read throttle through rsp_space
    dc_fifo #(
        .WIDTH         (DATA_WIDTH),
        .DEPTH         (RSP_FIFO_DEPTH),
        .WR_SYNC_DEPTH (M0_SYNC_DEPTH),
        .RD_SYNC_DEPTH (S0_SYNC_DEPTH)
    ) u_rsp_fifo (
        .in_clk      (m0_clk),
        .in_reset_n  (m0_reset_n),
        .out_clk     (s0_clk),
        .out_reset_n (s0_reset_n),
        .in_data     (m0_readdata),
        .in_valid    (m0_readdatavalid),
        .in_ready    (),
        .out_data    (s0_readdata),
        .out_valid   (s0_readdatavalid),
        .out_ready   (1'b1),
        .space_avail (rsp_space)
    );

endmodule

`default_nettype wire

// File: rtl/m0_issue_ctrl.sv
/*
 * m0 side command issue with read throttle
 * reads stop once pending words plus two max bursts exceed response space
 * a read already presented and stalled is never withdrawn
 */
`timescale 1ns/1ps
`default_nettype none

module m0_issue_ctrl #(
    parameter int BURSTCOUNT_WIDTH = 3,
    parameter int RSP_FIFO_DEPTH   = 8
) (
    input  logic                                            m0_clk,
    input  logic                                            m0_reset_n,
    input  logic                                            cmd_valid,
    input  logic                                            cmd_read,
    input  logic                                            cmd_write,
    input  logic [BURSTCOUNT_WIDTH-1:0]                     cmd_burstcount,
    output logic                                            cmd_ready,
    input  logic                                            m0_ready,
    input  logic                                            m0_readdatavalid,
    input  logic [mm_bridge_pkg::cnt_width(RSP_FIFO_DEPTH)-1:0] space_avail,
    output logic                                            m0_read,
    output logic                                            m0_write
);

    import mm_bridge_pkg::*;

    localparam int CW = cnt_width(RSP_FIFO_DEPTH);

    logic [CW-1:0] pending_cnt;
    logic [CW-1:0] burst_words;
    logic          read_acc;
    logic          stop_nxt;
    logic          stop_q;
    logic          read_stalled_q;

    // ------------------------------------------------------------------------
    // bus gating
    // ------------------------------------------------------------------------
    // writes never throttled
    assign m0_write = cmd_valid & cmd_write;
    // a stalled read keeps going even if stop rose meanwhile
    assign m0_read  = cmd_valid & cmd_read & (~stop_q | read_stalled_q);
    // hold the FIFO head while a read is blocked
    assign cmd_ready = m0_ready & ~(cmd_read & stop_q & ~read_stalled_q);

    assign read_acc    = m0_read & m0_ready;
    // burstcount never exceeds MAX_BURST
    assign burst_words = CW'(cmd_burstcount);

    // ------------------------------------------------------------------------
    // pending read words
    // ------------------------------------------------------------------------
    // add and subtract together when both happen in one cycle
    always_ff @(posedge m0_clk or negedge m0_reset_n) begin
        if (!m0_reset_n) begin
            pending_cnt <= '0;
        end else if (read_acc || m0_readdatavalid) begin
            pending_cnt <= pending_cnt
                         + (read_acc ? burst_words : CW'(0))
                         - (m0_readdatavalid ? CW'(1) : CW'(0));
        end
    end

    // margin of two bursts covers the registered stop and sync lag
    assign stop_nxt = (int'(pending_cnt) + 2 * MAX_BURST) > int'(space_avail);

    always_ff @(posedge m0_clk or negedge m0_reset_n) begin
        if (!m0_reset_n) begin
            stop_q         <= 1'b0;
            read_stalled_q <= 1'b0;
        end else begin
            stop_q         <= stop_nxt;
            read_stalled_q <= m0_read & ~m0_ready;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dc_fifo.sv
/*
 * dual-clock FIFO, Gray pointers, valid/ready on both ports
 * DEPTH must be a power of two; in_ready stays low through reset
 * space_avail is the write side view and lags reads by the sync delay
 */
`timescale 1ns/1ps
`default_nettype none

module dc_fifo #(
    parameter int WIDTH         = 8,
    parameter int DEPTH         = 8,
    parameter int WR_SYNC_DEPTH = 2,
    parameter int RD_SYNC_DEPTH = 2
) (
    input  logic                                   in_clk,
    input  logic                                   in_reset_n,
    input  logic                                   out_clk,
    input  logic                                   out_reset_n,
    input  logic [WIDTH-1:0]                       in_data,
    input  logic                                   in_valid,
    output logic                                   in_ready,
    output logic [WIDTH-1:0]                       out_data,
    output logic                                   out_valid,
    input  logic                                   out_ready,
    output logic [mm_bridge_pkg::cnt_width(DEPTH)-1:0] space_avail
);

    import mm_bridge_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam int PW = AW + 1;
    localparam int SW = cnt_width(DEPTH);
    // top two bits differ when write is one lap ahead of read
    localparam logic [PW-1:0] FULL_MASK = PW'(3) << (AW - 1);

    function automatic logic [PW-1:0] gray2bin(input logic [PW-1:0] g);
        logic [PW-1:0] b;
        b[PW-1] = g[PW-1];
        for (int i = PW - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    logic [WIDTH-1:0] mem [DEPTH];

    // read pointer in Gray code, crosses into the write clock
    logic [PW-1:0] rd_ptr_gray;

    // ------------------------------------------------------------------------
    // write side (in_clk)
    // ------------------------------------------------------------------------
    logic [PW-1:0] wr_ptr_bin;
    logic [PW-1:0] wr_ptr_gray;
    logic [PW-1:0] wr_ptr_bin_nxt;
    logic [PW-1:0] rd_gray_wsync;
    logic [PW-1:0] wr_occ;
    logic          full;
    logic          in_ready_en_q;
    logic          wr_en;

    assign wr_ptr_bin_nxt = wr_ptr_bin + 1'b1;
    assign full           = (wr_ptr_gray ^ rd_gray_wsync) == FULL_MASK;
    assign in_ready       = in_ready_en_q & ~full;
    assign wr_en          = in_valid & in_ready;

    // occupancy as seen from the write clock
    assign wr_occ      = wr_ptr_bin - gray2bin(rd_gray_wsync);
    assign space_avail = SW'(DEPTH) - SW'(wr_occ);

    // released one in_clk edge after reset, holds off the host
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            in_ready_en_q <= 1'b0;
            wr_ptr_bin    <= '0;
            wr_ptr_gray   <= '0;
        end else begin
            in_ready_en_q <= 1'b1;
            if (wr_en) begin
                wr_ptr_bin  <= wr_ptr_bin_nxt;
                wr_ptr_gray <= (wr_ptr_bin_nxt >> 1) ^ wr_ptr_bin_nxt;
            end
        end
    end

    // storage, no reset
    always_ff @(posedge in_clk) begin
        if (wr_en) begin
            mem[wr_ptr_bin[AW-1:0]] <= in_data;
        end
    end

    // read pointer into the write clock
    gray_ptr_sync #(
        .WIDTH (PW),
        .DEPTH (WR_SYNC_DEPTH)
    ) u_rd_ptr_sync (
        .clk      (in_clk),
        .reset_n  (in_reset_n),
        .ptr_gray (rd_ptr_gray),
        .ptr_sync (rd_gray_wsync)
    );

    // ------------------------------------------------------------------------
    // read side (out_clk)
    // ------------------------------------------------------------------------
    logic [PW-1:0] rd_ptr_bin;
    logic [PW-1:0] rd_ptr_bin_nxt;
    logic [PW-1:0] wr_gray_rsync;
    logic          rd_en;

    // empty when both Gray pointers match
    assign out_valid      = rd_ptr_gray != wr_gray_rsync;
    assign rd_en          = out_valid & out_ready;
    assign rd_ptr_bin_nxt = rd_ptr_bin + 1'b1;

    // head word register, reloaded every edge so it follows the read pointer
    always_ff @(posedge out_clk) begin
        if (rd_en) begin
            out_data <= mem[rd_ptr_bin_nxt[AW-1:0]];
        end else begin
            out_data <= mem[rd_ptr_bin[AW-1:0]];
        end
    end

    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            rd_ptr_bin  <= '0;
            rd_ptr_gray <= '0;
        end else if (rd_en) begin
            rd_ptr_bin  <= rd_ptr_bin_nxt;
            rd_ptr_gray <= (rd_ptr_bin_nxt >> 1) ^ rd_ptr_bin_nxt;
        end
    end

    // write pointer into the read clock
    gray_ptr_sync #(
        .WIDTH (PW),
        .DEPTH (RD_SYNC_DEPTH)
    ) u_wr_ptr_sync (
        .clk      (out_clk),
        .reset_n  (out_reset_n),
        .ptr_gray (wr_ptr_gray),
        .ptr_sync (wr_gray_rsync)
    );

endmodule

`default_nettype wire

// File: rtl/gray_ptr_sync.sv
/*
 * flop chain for a Gray coded FIFO pointer entering another clock
 * only one bit may change per source edge, DEPTH must be at least 2
 */
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_sync #(
    parameter int WIDTH = 4,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic [WIDTH-1:0] ptr_gray,
    output logic [WIDTH-1:0] ptr_sync
);

    // stage 0 is the metastable capture flop
    logic [WIDTH-1:0] sync_q [DEPTH];

    // chain clears to zero so both sides agree the FIFO is empty
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= ptr_gray;
            for (int i = 1; i < DEPTH; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // last stage is the settled copy
    assign ptr_sync = sync_q[DEPTH-1];

endmodule

`default_nettype wire

// File: rtl/mm_bridge_pkg.sv
/*
 * shared constants for the Avalon-MM clock crossing bridge
 * bursts are limited to MAX_BURST words, FIFO depths must be powers of two
 */
`default_nettype none

package mm_bridge_pkg;

    // ------------------------------------------------------------------------
    // burst limit
    // ------------------------------------------------------------------------
    localparam int MAX_BURST = 2;

    // default bus widths
    localparam int DEF_DATA_WIDTH       = 32;
    localparam int DEF_ADDR_WIDTH       = 16;
    localparam int DEF_BURSTCOUNT_WIDTH = 3;

    // default FIFO depths and synchronizer length
    localparam int DEF_CMD_FIFO_DEPTH = 8;
    localparam int DEF_RSP_FIFO_DEPTH = 8;
    localparam int DEF_SYNC_DEPTH     = 2;

    // bits needed to hold a count from 0 up to depth, inclusive
    function automatic int cnt_width(input int depth);
        int w;
        w = 1;
        while ((1 << w) <= depth) begin
            w++;
        end
        return w;
    endfunction

endpackage

`default_nettype wire
